//--- spi_pkg.sv
//--------------------
// shared sizes, enums and the request struct for the spi master
// blocks and testbench refer to these by scoped names
//--------------------
package spi_pkg;

  //--------------------
  // sizes
  //--------------------
  // chip selects on the bus
  localparam int num_slaves  = 4;
  // width of the slave index in a request
  localparam int cs_width    = $clog2(num_slaves);
  // bits per transfer
  localparam int data_width  = 8;
  // ct2 and t2c delay fields
  localparam int delay_width = 4;
  // baud divider field, sclk cycles per half period
  localparam int div_width   = 4;
  // physical mosi / miso lanes
  localparam int lane_width  = 4;
  // beat counter, holds beats - 1 for single mode
  localparam int beat_width  = $clog2(data_width);

  //--------------------
  // enums
  //--------------------
  // bits moved per beat: 1, 2 or 4
  typedef enum logic [1:0] {
    lane_single,
    lane_dual,
    lane_quad
  } lane_mode_e;

  // controller sequence
  typedef enum logic [1:0] {
    st_idle,
    st_setup,
    st_shift,
    st_hold
  } ctrl_state_e;

  // host request, sampled with an accepted start
  typedef struct packed {
    logic [cs_width-1:0]    cs_index;
    lane_mode_e             mode;
    logic [data_width-1:0]  tx_data;
    logic [delay_width-1:0] ct2_delay;
    logic [delay_width-1:0] t2c_delay;
    logic [div_width-1:0]   baud_div;
  } spi_req_t;

  // index of the last beat for a lane mode, 8 / 4 / 2 beats
  function automatic logic [beat_width-1:0] last_beat(lane_mode_e mode);
    case (mode)
      lane_dual: return beat_width'(3);
      lane_quad: return beat_width'(1);
      default:   return beat_width'(7);
    endcase
  endfunction

endpackage

//--- spi_baud_gen.sv
//--------------------
// serial clock generator for spi mode 0
// spi_clk idles low, half period is baud_div sclk cycles
// ticks mark the cycle whose closing edge toggles spi_clk
//--------------------
module spi_baud_gen (
  input  logic                           sclk,
  input  logic                           reset,
  input  logic                           clk_en,
  input  logic [spi_pkg::div_width-1:0]  baud_div,
  output logic                           spi_clk,
  output logic                           rise_tick,
  output logic                           fall_tick
);

  // half period counter
  logic [spi_pkg::div_width-1:0] cnt_q;
  logic [spi_pkg::div_width-1:0] cnt_last;
  logic                          spi_clk_q;
  logic                          toggle;

  // last count of a half period
  assign cnt_last = baud_div - spi_pkg::div_width'(1);
  assign toggle   = clk_en && (cnt_q == cnt_last);

  // direction of the coming edge
  assign rise_tick = toggle && !spi_clk_q;
  assign fall_tick = toggle && spi_clk_q;
  assign spi_clk   = spi_clk_q;

  always_ff @(posedge sclk) begin
    if (reset) begin
      cnt_q     <= '0;
      spi_clk_q <= 1'b0;
    end else if (!clk_en) begin
      // parked, so the first half after enable is low
      cnt_q     <= '0;
      spi_clk_q <= 1'b0;
    end else if (toggle) begin
      cnt_q     <= '0;
      spi_clk_q <= ~spi_clk_q;
    end else begin
      cnt_q <= cnt_q + spi_pkg::div_width'(1);
    end
  end

  //--------------------
  // checks
  //--------------------
  // one edge at a time
  a_tick_excl: assert property (
    @(posedge sclk) disable iff (reset)
    !(rise_tick && fall_tick)
  ) else $error("rise_tick and fall_tick high together");

endmodule

//--- spi_lane_shifter.sv
//--------------------
// transmit / receive byte for one transfer, msb first
// moves 1, 2 or 4 bits per beat, mode is latched at load
//--------------------
module spi_lane_shifter (
  input  logic                            sclk,
  input  logic                            reset,
  input  logic                            load,
  input  logic [spi_pkg::data_width-1:0]  tx_data,
  input  spi_pkg::lane_mode_e             mode,
  input  logic                            sample,
  input  logic                            shift,
  input  logic [spi_pkg::lane_width-1:0]  miso,
  output logic [spi_pkg::lane_width-1:0]  mosi,
  output logic [spi_pkg::data_width-1:0]  rx_byte
);

  logic [spi_pkg::data_width-1:0]  tx_q;
  logic [spi_pkg::data_width-1:0]  rx_q;
  logic [spi_pkg::data_width-1:0]  rx_next;
  logic [spi_pkg::data_width-1:0]  rx_byte_q;
  spi_pkg::lane_mode_e             mode_q;
  // samples left before the byte is full
  logic [spi_pkg::beat_width-1:0] smp_cnt_q;

  //--------------------
  // lane map
  //--------------------
  // top bits of tx go out, unused lanes stay 0
  always_comb begin
    mosi = '0;
    case (mode_q)
      // lane 1 carries the higher bit
      spi_pkg::lane_dual: mosi[1:0] = tx_q[spi_pkg::data_width-1 -: 2];
      // lane 3 carries the highest bit of the nibble
      spi_pkg::lane_quad: mosi[3:0] = tx_q[spi_pkg::data_width-1 -: 4];
      default:            mosi[0]   = tx_q[spi_pkg::data_width-1];
    endcase
  end

  // receive uses the same map on miso
  always_comb begin
    case (mode_q)
      spi_pkg::lane_dual: rx_next = {rx_q[spi_pkg::data_width-3:0], miso[1:0]};
      spi_pkg::lane_quad: rx_next = {rx_q[spi_pkg::data_width-5:0], miso[3:0]};
      default:            rx_next = {rx_q[spi_pkg::data_width-2:0], miso[0]};
    endcase
  end

  //--------------------
  // transmit side
  //--------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      tx_q   <= '0;
      mode_q <= spi_pkg::lane_single;
    end else if (load) begin
      tx_q   <= tx_data;
      mode_q <= mode;
    end else if (shift) begin
      // zeros fill in, so mosi ends at 0
      case (mode_q)
        spi_pkg::lane_dual: tx_q <= tx_q << 2;
        spi_pkg::lane_quad: tx_q <= tx_q << 4;
        default:            tx_q <= tx_q << 1;
      endcase
    end
  end

  //--------------------
  // receive side
  //--------------------
  always_ff @(posedge sclk) begin
    if (sample) begin
      rx_q <= rx_next;
    end
  end

  // rx_byte only moves on the last sample of a transfer
  always_ff @(posedge sclk) begin
    if (reset) begin
      smp_cnt_q <= '0;
      rx_byte_q <= '0;
    end else if (load) begin
      smp_cnt_q <= spi_pkg::last_beat(mode);
    end else if (sample) begin
      if (smp_cnt_q == '0) begin
        rx_byte_q <= rx_next;
      end else begin
        smp_cnt_q <= smp_cnt_q - spi_pkg::beat_width'(1);
      end
    end
  end

  assign rx_byte = rx_byte_q;

  //--------------------
  // checks
  //--------------------
  // mosi moves only right after a load or a shift
  a_mosi_stable: assert property (
    @(posedge sclk) disable iff (reset)
    !($past(load) || $past(shift)) |-> $stable(mosi)
  ) else $error("mosi changed outside a load or shift");

endmodule

//--- spi_master_ctrl.sv
//--------------------
// spi master sequencer: setup delay, shift beats, hold delay
// decodes the chip select and drives the clock and shifter strobes
//--------------------
module spi_master_ctrl (
  input  logic                            sclk,
  input  logic                            reset,
  input  logic                            start,
  input  spi_pkg::spi_req_t               req,
  input  logic                            rise_tick,
  input  logic                            fall_tick,
  output logic                            clk_en,
  output logic [spi_pkg::div_width-1:0]   baud_div,
  output logic                            load,
  output logic                            sample,
  output logic                            shift,
  output spi_pkg::lane_mode_e             mode,
  output logic [spi_pkg::data_width-1:0]  tx_data,
  output logic [spi_pkg::num_slaves-1:0]  cs_n,
  output logic                            busy,
  output logic                            done
);

  spi_pkg::ctrl_state_e             state_q;
  // shared by setup and hold
  logic [spi_pkg::delay_width-1:0]  dly_q;
  logic [spi_pkg::beat_width-1:0]   beat_q;
  logic                             done_q;
  logic                             accept;
  // latched request fields
  logic [spi_pkg::cs_width-1:0]     cs_q;
  logic [spi_pkg::delay_width-1:0]  t2c_q;
  logic [spi_pkg::div_width-1:0]    div_q;

  // a start while busy is dropped
  assign accept = start && (state_q == spi_pkg::st_idle);

  // shifter loads in the start cycle, mosi is ready in cycle 1
  assign load    = accept;
  assign tx_data = req.tx_data;
  assign mode    = req.mode;

  // clock runs only while shifting
  assign clk_en   = (state_q == spi_pkg::st_shift);
  assign baud_div = div_q;
  assign sample   = clk_en && rise_tick;
  assign shift    = clk_en && fall_tick;

  assign busy = (state_q != spi_pkg::st_idle);
  assign done = done_q;

  // one-cold select for the latched slave
  always_comb begin
    cs_n = '1;
    if (state_q != spi_pkg::st_idle) begin
      cs_n[cs_q] = 1'b0;
    end
  end

  always_ff @(posedge sclk) begin
    if (accept) begin
      cs_q  <= req.cs_index;
      t2c_q <= req.t2c_delay;
      div_q <= req.baud_div;
    end
  end

  //--------------------
  // sequence
  //--------------------
  always_ff @(posedge sclk) begin
    if (reset) begin
      state_q <= spi_pkg::st_idle;
      dly_q   <= '0;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        spi_pkg::st_idle: begin
          if (accept) begin
            beat_q <= spi_pkg::last_beat(req.mode);
            // zero delay goes straight to the beats
            if (req.ct2_delay == '0) begin
              state_q <= spi_pkg::st_shift;
            end else begin
              state_q <= spi_pkg::st_setup;
              dly_q   <= req.ct2_delay - spi_pkg::delay_width'(1);
            end
          end
        end
        spi_pkg::st_setup: begin
          if (dly_q == '0) begin
            state_q <= spi_pkg::st_shift;
          end else begin
            dly_q <= dly_q - spi_pkg::delay_width'(1);
          end
        end
        spi_pkg::st_shift: begin
          // beats end on the last falling edge
          if (fall_tick) begin
            if (beat_q != '0) begin
              beat_q <= beat_q - spi_pkg::beat_width'(1);
            end else if (t2c_q == '0) begin
              state_q <= spi_pkg::st_idle;
              done_q  <= 1'b1;
            end else begin
              state_q <= spi_pkg::st_hold;
              dly_q   <= t2c_q - spi_pkg::delay_width'(1);
            end
          end
        end
        default: begin
          // hold, then release cs with done
          if (dly_q == '0) begin
            state_q <= spi_pkg::st_idle;
            done_q  <= 1'b1;
          end else begin
            dly_q <= dly_q - spi_pkg::delay_width'(1);
          end
        end
      endcase
    end
  end

  //--------------------
  // checks
  //--------------------
  a_cs_onecold: assert property (
    @(posedge sclk) disable iff (reset)
    $onehot0(~cs_n)
  ) else $error("more than one chip select low");

  // done only closes a running transfer
  a_done_src: assert property (
    @(posedge sclk) disable iff (reset)
    done |-> ($past(state_q) != spi_pkg::st_idle)
  ) else $error("done without a transfer");

endmodule

//--- spi_master.sv
//--------------------
// quad capable spi master, mode 0, one byte per start
// ties the sequencer, clock divider and lane shifter together
//--------------------
module spi_master (
  input  logic                            sclk,
  input  logic                            reset,
  input  logic                            start,
  input  spi_pkg::spi_req_t               req,
  output logic                            busy,
  output logic                            done,
  output logic [spi_pkg::data_width-1:0]  rx_data,
  output logic                            spi_clk,
  output logic [spi_pkg::num_slaves-1:0]  cs_n,
  output logic [spi_pkg::lane_width-1:0]  mosi,
  input  logic [spi_pkg::lane_width-1:0]  miso
);

  // sequencer to clock divider
  logic                            clk_en;
  logic [spi_pkg::div_width-1:0]   baud_div;
  logic                            rise_tick;
  logic                            fall_tick;
  // sequencer to shifter
  logic                            load;
  logic                            sample;
  logic                            shift;
  spi_pkg::lane_mode_e             mode;
  logic [spi_pkg::data_width-1:0]  tx_data;

  spi_master_ctrl u_ctrl (
    .sclk      (sclk),
    .reset     (reset),
    .start     (start),
    .req       (req),
    .rise_tick (rise_tick),
    .fall_tick (fall_tick),
    .clk_en    (clk_en),
    .baud_div  (baud_div),
    .load      (load),
    .sample    (sample),
    .shift     (shift),
    .mode      (mode),
    .tx_data   (tx_data),
    .cs_n      (cs_n),
    .busy      (busy),
    .done      (done)
  );

  spi_baud_gen u_baud (
    .sclk      (sclk),
    .reset     (reset),
    .clk_en    (clk_en),
    .baud_div  (baud_div),
    .spi_clk   (spi_clk),
    .rise_tick (rise_tick),
    .fall_tick (fall_tick)
  );

  spi_lane_shifter u_shifter (
    .sclk    (sclk),
    .reset   (reset),
    .load    (load),
    .tx_data (tx_data),
    .mode    (mode),
    .sample  (sample),
    .shift   (shift),
    .miso    (miso),
    .mosi    (mosi),
    .rx_byte (rx_data)
  );

  // idle bus: all selects high, clock parked low
  a_idle_bus: assert property (
    @(posedge sclk) disable iff (reset)
    (u_ctrl.state_q == spi_pkg::st_idle) |-> (cs_n == '1 && !spi_clk)
  ) else $error("bus active while sequencer idle");

endmodule

//--- tb_clock_gen.sv
//--------------------
// testbench clock and reset source
// sclk period 100 ns, reset high for the first 10 rising edges
//--------------------
module tb_clock_gen (
  output logic sclk,
  output logic reset
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    sclk = 1'b0;
    forever begin
      #50 sclk = ~sclk;
    end
  end

  // release on a rising edge, like any other driven input
  initial begin
    reset = 1'b1;
    repeat (10) @(posedge sclk);
    reset <= 1'b0;
  end

endmodule

//--- tb_spi_slave.sv
//--------------------
// behavioral mode 0 slave for the testbench
// returns reply on miso msb first and collects the mosi byte
//--------------------
module tb_spi_slave (
  input  logic                            spi_clk,
  input  logic [spi_pkg::num_slaves-1:0]  cs_n,
  input  logic [spi_pkg::lane_width-1:0]  mosi,
  input  spi_pkg::lane_mode_e             mode,
  input  logic [spi_pkg::data_width-1:0]  reply,
  output logic [spi_pkg::lane_width-1:0]  miso,
  output logic [spi_pkg::data_width-1:0]  collected
);
  timeunit 1ns;
  timeprecision 1ps;

  logic       sel;
  // set once the reply is loaded for this select
  logic       armed = 1'b0;
  logic [7:0] out_sr;
  logic [7:0] in_sr;

  // any select low counts
  assign sel       = (cs_n != '1);
  assign collected = in_sr;

  //--------------------
  // miso side
  //--------------------
  // load on select, then move on every falling spi_clk
  always @(posedge sel or negedge sel or negedge spi_clk) begin
    if (!sel) begin
      armed <= 1'b0;
    end else if (!armed) begin
      out_sr <= reply;
      armed  <= 1'b1;
    end else begin
      case (mode)
        spi_pkg::lane_dual: out_sr <= out_sr << 2;
        spi_pkg::lane_quad: out_sr <= out_sr << 4;
        default:            out_sr <= out_sr << 1;
      endcase
    end
  end

  // unused lanes carry ones, the master must ignore them
  always_comb begin
    miso = '0;
    if (sel) begin
      case (mode)
        spi_pkg::lane_dual: miso = {2'b11, out_sr[7:6]};
        spi_pkg::lane_quad: miso = out_sr[7:4];
        default:            miso = {3'b111, out_sr[7]};
      endcase
    end
  end

  //--------------------
  // mosi side
  //--------------------
  // lane 0 single, lane 1 high bit for dual, lane 3 high bit for quad
  always @(posedge spi_clk) begin
    if (sel) begin
      case (mode)
        spi_pkg::lane_dual: in_sr <= {in_sr[5:0], mosi[1:0]};
        spi_pkg::lane_quad: in_sr <= {in_sr[3:0], mosi[3:0]};
        default:            in_sr <= {in_sr[6:0], mosi[0]};
      endcase
    end
  end

endmodule

//--- tb_spi_master.sv
//--------------------
// testbench for the spi master: lfsr requests in all lane modes
// concurrent checks on data, selects, timing and mosi lanes
//--------------------
module tb_spi_master;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int n_transfers = 24;
  // longest transfer is 1 + 15 + 8 * 2 * 4 + 15 cycles
  localparam int done_limit  = 200;

  logic                           sclk;
  logic                           reset;
  logic                           start;
  spi_pkg::spi_req_t              req;
  logic                           busy;
  logic                           done;
  logic [spi_pkg::data_width-1:0] rx_data;
  logic                           spi_clk;
  logic [spi_pkg::num_slaves-1:0] cs_n;
  logic [spi_pkg::lane_width-1:0] mosi;
  logic [spi_pkg::lane_width-1:0] miso;
  spi_pkg::lane_mode_e            slave_mode;
  logic [7:0]                     slave_reply;
  logic [7:0]                     slave_rx;

  // expected side, captured on an accepted start
  spi_pkg::spi_req_t req_q;
  logic [7:0]        reply_q;
  int                cyc_q;
  int                acc_cnt_q;
  int                done_cnt_q;
  // mosi one cycle back
  logic [spi_pkg::lane_width-1:0] mosi_q;
  int                errors = 0;
  int                timeouts = 0;
  logic [16:0]       lfsr;

  tb_clock_gen u_clk (
    .sclk  (sclk),
    .reset (reset)
  );

  spi_master u_spi_master (
    .sclk    (sclk),
    .reset   (reset),
    .start   (start),
    .req     (req),
    .busy    (busy),
    .done    (done),
    .rx_data (rx_data),
    .spi_clk (spi_clk),
    .cs_n    (cs_n),
    .mosi    (mosi),
    .miso    (miso)
  );

  tb_spi_slave u_slave (
    .spi_clk   (spi_clk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .mode      (slave_mode),
    .reply     (slave_reply),
    .miso      (miso),
    .collected (slave_rx)
  );

  //--------------------
  // reference rules
  //--------------------
  function automatic int beats_for(spi_pkg::lane_mode_e mode);
    case (mode)
      spi_pkg::lane_dual: return 4;
      spi_pkg::lane_quad: return 2;
      default:            return 8;
    endcase
  endfunction

  function automatic logic [3:0] lane_mask(spi_pkg::lane_mode_e mode);
    case (mode)
      spi_pkg::lane_dual: return 4'b0011;
      spi_pkg::lane_quad: return 4'b1111;
      default:            return 4'b0001;
    endcase
  endfunction

  // start to done, counted from the edge that drives start
  function automatic int transfer_cycles(spi_pkg::spi_req_t r);
    return 1 + int'(r.ct2_delay) + beats_for(r.mode) * 2 * int'(r.baud_div)
      + int'(r.t2c_delay);
  endfunction

  function automatic logic [spi_pkg::num_slaves-1:0] cs_expect(logic [1:0] idx);
    return ~(spi_pkg::num_slaves'(1) << idx);
  endfunction

  function automatic spi_pkg::lane_mode_e mode_for(int idx);
    case (idx % 3)
      0:       return spi_pkg::lane_single;
      1:       return spi_pkg::lane_dual;
      default: return spi_pkg::lane_quad;
    endcase
  endfunction

  // fibonacci lfsr, x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(logic [16:0] s);
    return {s[15:0], s[16] ^ s[13]};
  endfunction

  // one lfsr step per bit
  task automatic take_bits(input int n, output logic [7:0] v);
    v = '0;
    for (int b = 0; b < n; b++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic make_request(input int idx, output spi_pkg::spi_req_t r,
                              output logic [7:0] reply);
    logic [7:0] v;
    r      = '0;
    r.mode = mode_for(idx);
    take_bits(2, v);
    r.cs_index = v[1:0];
    take_bits(8, v);
    r.tx_data = v;
    take_bits(4, v);
    r.ct2_delay = v[3:0];
    take_bits(4, v);
    r.t2c_delay = v[3:0];
    // divider 1 to 4
    take_bits(2, v);
    r.baud_div = {2'b00, v[1:0]} + 4'd1;
    take_bits(8, v);
    reply = v;
  endtask

  //--------------------
  // drivers
  //--------------------
  task automatic send_request(input spi_pkg::spi_req_t r, input logic [7:0] reply);
    @(posedge sclk);
    start       <= 1'b1;
    req         <= r;
    slave_mode  <= r.mode;
    slave_reply <= reply;
    @(posedge sclk);
    start <= 1'b0;
  endtask

  // slave side left alone, the master should drop this one
  task automatic start_while_busy(input spi_pkg::spi_req_t r);
    @(posedge sclk);
    start <= 1'b1;
    req   <= r;
    @(posedge sclk);
    start <= 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    do begin
      @(negedge sclk);
      n++;
    end while (!done && n < done_limit);
    if (!done) begin
      timeouts++;
      $display("timeout: no done within %0d cycles of start", done_limit);
    end
  endtask

  // request capture and cycle count
  always @(posedge sclk) begin
    mosi_q <= mosi;
    if (reset) begin
      cyc_q      <= 0;
      acc_cnt_q  <= 0;
      done_cnt_q <= 0;
    end else begin
      if (start && !busy) begin
        req_q     <= req;
        reply_q   <= slave_reply;
        cyc_q     <= 1;
        acc_cnt_q <= acc_cnt_q + 1;
      end else if (busy) begin
        cyc_q <= cyc_q + 1;
      end
      if (done) begin
        done_cnt_q <= done_cnt_q + 1;
      end
    end
  end

  //--------------------
  // checks
  //--------------------
  a_reset_state: assert property (
    @(posedge sclk) $fell(reset) |->
      (cs_n == '1 && !spi_clk && !busy && mosi == '0)
  ) else begin
    errors++;
    $display("FAIL cs_n exp 0xf got 0x%h, spi_clk exp 0x0 got 0x%h", $sampled(cs_n),
             $sampled(spi_clk));
    $display("FAIL busy exp 0x0 got 0x%h, mosi exp 0x0 got 0x%h", $sampled(busy),
             $sampled(mosi));
  end

  a_rx_data: assert property (
    @(posedge sclk) disable iff (reset)
    done |-> (rx_data == reply_q)
  ) else begin
    errors++;
    $display("FAIL rx_data exp 0x%h got 0x%h", reply_q, $sampled(rx_data));
  end

  a_slave_rx: assert property (
    @(posedge sclk) disable iff (reset)
    done |-> (slave_rx == req_q.tx_data)
  ) else begin
    errors++;
    $display("FAIL slave_rx exp 0x%h got 0x%h", req_q.tx_data, $sampled(slave_rx));
  end

  a_cs_sel: assert property (
    @(posedge sclk) disable iff (reset)
    busy |-> (cs_n == cs_expect(req_q.cs_index))
  ) else begin
    errors++;
    $display("FAIL cs_n exp 0x%h got 0x%h", cs_expect(req_q.cs_index), $sampled(cs_n));
  end

  // idle bus
  a_cs_idle: assert property (
    @(posedge sclk) disable iff (reset)
    !busy |-> ((cs_n == '1) && !spi_clk)
  ) else begin
    errors++;
    $display("FAIL idle cs_n exp 0xf got 0x%h, spi_clk exp 0x0 got 0x%h",
             $sampled(cs_n), $sampled(spi_clk));
  end

  a_cycles: assert property (
    @(posedge sclk) disable iff (reset)
    done |-> (cyc_q == transfer_cycles(req_q))
  ) else begin
    errors++;
    $display("FAIL cycles exp 0x%h got 0x%h", transfer_cycles(req_q), $sampled(cyc_q));
  end

  // data moves only on the falling edge
  a_mosi_high: assert property (
    @(posedge sclk) disable iff (reset)
    spi_clk |-> $stable(mosi)
  ) else begin
    errors++;
    $display("FAIL mosi exp 0x%h got 0x%h", $sampled(mosi_q), $sampled(mosi));
  end

  a_mosi_unused: assert property (
    @(posedge sclk) disable iff (reset)
    busy |-> ((mosi & ~lane_mask(req_q.mode)) == '0)
  ) else begin
    errors++;
    $display("FAIL mosi unused lanes exp 0x0 got 0x%h",
             $sampled(mosi) & ~lane_mask(req_q.mode));
  end

  // one done per accepted start
  a_one_done: assert property (
    @(posedge sclk) disable iff (reset)
    done |-> (done_cnt_q + 1 == acc_cnt_q)
  ) else begin
    errors++;
    $display("FAIL done count exp 0x%h got 0x%h", acc_cnt_q, $sampled(done_cnt_q) + 1);
  end

  //--------------------
  // stimulus
  //--------------------
  initial begin
    int                n;
    spi_pkg::spi_req_t r;
    spi_pkg::spi_req_t r_extra;
    logic [7:0]        reply;
    logic [7:0]        unused_reply;
    start       = 1'b0;
    req         = '0;
    slave_mode  = spi_pkg::lane_single;
    slave_reply = '0;
    lfsr        = 17'd82285;

    n = 0;
    do begin
      @(negedge sclk);
      n++;
    end while (reset && n < 50);
    if (reset) begin
      timeouts++;
      $display("timeout: reset never released");
    end

    for (int i = 0; i < n_transfers; i++) begin
      make_request(i, r, reply);
      send_request(r, reply);
      // every other transfer gets a second start mid-flight
      if (i % 2 == 1) begin
        make_request(i + 1, r_extra, unused_reply);
        start_while_busy(r_extra);
      end
      wait_done();
    end

    // let the last checks see the closing cycles
    repeat (4) @(posedge sclk);
    $display("transfers %0d, errors %0d, timeouts %0d", done_cnt_q, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- project.f
spi_pkg.sv
spi_baud_gen.sv
spi_lane_shifter.sv
spi_master_ctrl.sv
spi_master.sv
tb_clock_gen.sv
tb_spi_slave.sv
tb_spi_master.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_spi_master
FILELIST = project.f

OBJ_DIR  = obj_dir
BIN      = $(OBJ_DIR)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^PASS: all tests$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
